// File: verilog/ffe_config.svh
`ifndef FFE_CONFIG_SVH
`define FFE_CONFIG_SVH

// Equalizer geometry. FFE_LENGTH must not exceed FFE_WIDTH.
`define FFE_LENGTH        4
`define FFE_WIDTH         4

// Datapath widths, all signed except the shift.
`define FFE_CODE_BITS     8
`define FFE_WEIGHT_BITS   10
`define FFE_RESULT_BITS   8
`define FFE_SHIFT_BITS    4

// AXI4-Lite byte address width.
`define FFE_ADDR_BITS     8

// Weight (tap i, channel j) sits at FFE_WEIGHT_BASE + 4*(i*FFE_WIDTH + j).
`define FFE_WEIGHT_BASE   'h00

// Shift for channel j sits at FFE_SHIFT_BASE + 4*j.
`define FFE_SHIFT_BASE    'h40

`endif

// File: verilog/ffe_dsp_pkg.sv
`include "ffe_config.svh"

package ffe_dsp_pkg;

   // Signed ADC code.
   typedef logic signed [`FFE_CODE_BITS-1:0] code_t;

   // Signed tap weight.
   typedef logic signed [`FFE_WEIGHT_BITS-1:0] weight_t;

   // Full-precision code times weight.
   typedef logic signed [`FFE_CODE_BITS+`FFE_WEIGHT_BITS-1:0] product_t;

   // Tap sum, two guard bits over a product.
   typedef logic signed [`FFE_CODE_BITS+`FFE_WEIGHT_BITS+1:0] acc_t;

   // Equalized output sample.
   typedef logic signed [`FFE_RESULT_BITS-1:0] result_t;

   // Right shift amount.
   typedef logic [`FFE_SHIFT_BITS-1:0] shift_t;

endpackage

// File: verilog/ffe_bus_pkg.sv
`include "ffe_config.svh"

package ffe_bus_pkg;

   // Byte address on the register bus.
   typedef logic [`FFE_ADDR_BITS-1:0] axi_addr_t;

   // Register data word.
   typedef logic [31:0] axi_data_t;

   // Response code.
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // Shared by the write and the read channel FSMs.
   typedef enum logic {
      IDLE,
      RESP
   } bus_state_e;

endpackage

// File: verilog/ffe_csr.sv
`timescale 1ns/100ps
`include "ffe_config.svh"

module ffe_csr (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ffe_bus_pkg::axi_addr_t awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  ffe_bus_pkg::axi_data_t wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output ffe_bus_pkg::axi_resp_t bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  ffe_bus_pkg::axi_addr_t araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output ffe_bus_pkg::axi_data_t rdata,
   output ffe_bus_pkg::axi_resp_t rresp,
   output logic                   rvalid,
   input  logic                   rready,
   output ffe_dsp_pkg::weight_t   weights [`FFE_LENGTH-1:0][`FFE_WIDTH-1:0],
   output ffe_dsp_pkg::shift_t    shifts  [`FFE_WIDTH-1:0]
);
   import ffe_bus_pkg::*;
   import ffe_dsp_pkg::*;

   localparam int NUM_WEIGHTS = `FFE_LENGTH * `FFE_WIDTH;

   // Word-aligned hit inside a window of words registers.
   function automatic logic in_window(input axi_addr_t a, input axi_addr_t base,
                                      input int words);
      axi_addr_t off;
      off = a - base;
      return (off[1:0] == 2'b00) && (off < axi_addr_t'(4 * words));
   endfunction

   function automatic int word_index(input axi_addr_t a, input axi_addr_t base);
      axi_addr_t off;
      off = a - base;
      return int'(off >> 2);
   endfunction

   bus_state_e wr_state;
   bus_state_e rd_state;
   logic       wr_go;
   logic       ar_go;
   logic       aw_weight;
   logic       aw_shift;
   logic       ar_weight;
   logic       ar_shift;
   int         aw_widx;
   int         aw_sidx;
   int         ar_widx;
   int         ar_sidx;
   axi_data_t  rd_word;

   // Address decode for both channels.
   assign aw_weight = in_window(awaddr, axi_addr_t'(`FFE_WEIGHT_BASE), NUM_WEIGHTS);
   assign aw_shift  = in_window(awaddr, axi_addr_t'(`FFE_SHIFT_BASE), `FFE_WIDTH);
   assign aw_widx   = word_index(awaddr, axi_addr_t'(`FFE_WEIGHT_BASE));
   assign aw_sidx   = word_index(awaddr, axi_addr_t'(`FFE_SHIFT_BASE));
   assign ar_weight = in_window(araddr, axi_addr_t'(`FFE_WEIGHT_BASE), NUM_WEIGHTS);
   assign ar_shift  = in_window(araddr, axi_addr_t'(`FFE_SHIFT_BASE), `FFE_WIDTH);
   assign ar_widx   = word_index(araddr, axi_addr_t'(`FFE_WEIGHT_BASE));
   assign ar_sidx   = word_index(araddr, axi_addr_t'(`FFE_SHIFT_BASE));

   // Address and data are taken together in one cycle.
   assign wr_go   = (wr_state == IDLE) && awvalid && wvalid;
   assign awready = wr_go;
   assign wready  = wr_go;
   assign ar_go   = (rd_state == IDLE) && arvalid && arready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_state <= IDLE;
         bvalid   <= 1'b0;
      end else begin
         case (wr_state)
            IDLE: begin
               if (wr_go) begin
                  wr_state <= RESP;
                  bvalid   <= 1'b1;
               end
            end
            RESP: begin
               if (bready) begin
                  wr_state <= IDLE;
                  bvalid   <= 1'b0;
               end
            end
            default: wr_state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_go) bresp <= (aw_weight || aw_shift) ? RESP_OKAY : RESP_SLVERR;
   end

   // Unmapped writes fall through both loops.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int t = 0; t < `FFE_LENGTH; t++) begin
            for (int c = 0; c < `FFE_WIDTH; c++) weights[t][c] <= '0;
         end
         for (int c = 0; c < `FFE_WIDTH; c++) shifts[c] <= '0;
      end else if (wr_go) begin
         for (int t = 0; t < `FFE_LENGTH; t++) begin
            for (int c = 0; c < `FFE_WIDTH; c++) begin
               if (aw_weight && aw_widx == t * `FFE_WIDTH + c)
                  weights[t][c] <= weight_t'(wdata[`FFE_WEIGHT_BITS-1:0]);
            end
         end
         for (int c = 0; c < `FFE_WIDTH; c++) begin
            if (aw_shift && aw_sidx == c) shifts[c] <= shift_t'(wdata[`FFE_SHIFT_BITS-1:0]);
         end
      end
   end

   // Weights sign-extend, shifts zero-extend.
   always_comb begin
      rd_word = '0;
      for (int t = 0; t < `FFE_LENGTH; t++) begin
         for (int c = 0; c < `FFE_WIDTH; c++) begin
            if (ar_weight && ar_widx == t * `FFE_WIDTH + c) rd_word = 32'(weights[t][c]);
         end
      end
      for (int c = 0; c < `FFE_WIDTH; c++) begin
         if (ar_shift && ar_sidx == c) rd_word = 32'(shifts[c]);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_state <= IDLE;
         arready  <= 1'b0;             // Rises one cycle after reset.
         rvalid   <= 1'b0;
      end else begin
         case (rd_state)
            IDLE: begin
               arready <= 1'b1;
               if (ar_go) begin
                  rd_state <= RESP;
                  arready  <= 1'b0;
                  rvalid   <= 1'b1;
               end
            end
            RESP: begin
               if (rready) begin
                  rd_state <= IDLE;
                  arready  <= 1'b1;
                  rvalid   <= 1'b0;
               end
            end
            default: rd_state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_go) begin
         rdata <= rd_word;
         rresp <= (ar_weight || ar_shift) ? RESP_OKAY : RESP_SLVERR;
      end
   end

endmodule

// File: verilog/ffe_mac_array.sv
`timescale 1ns/100ps
`include "ffe_config.svh"

module ffe_mac_array (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  ffe_dsp_pkg::code_t   in_codes [`FFE_WIDTH-1:0],
   input  ffe_dsp_pkg::weight_t weights  [`FFE_LENGTH-1:0][`FFE_WIDTH-1:0],
   output logic                 acc_valid,
   output ffe_dsp_pkg::acc_t    acc      [`FFE_WIDTH-1:0]
);
   import ffe_dsp_pkg::*;

   code_t    cur_codes  [`FFE_WIDTH-1:0];   // Latest valid block.
   code_t    prev_codes [`FFE_WIDTH-1:0];   // The valid block before it.
   logic     blk_valid;
   code_t    tap_x      [`FFE_WIDTH-1:0][`FFE_LENGTH-1:0];
   product_t prod       [`FFE_WIDTH-1:0][`FFE_LENGTH-1:0];
   logic     prod_valid;
   acc_t     tap_sum    [`FFE_WIDTH-1:0];

   // Input register. History moves only on valid blocks, so idle cycles are skipped.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         blk_valid <= 1'b0;
         for (int j = 0; j < `FFE_WIDTH; j++) begin
            cur_codes[j]  <= '0;
            prev_codes[j] <= '0;
         end
      end else begin
         blk_valid <= in_valid;
         if (in_valid) begin
            cur_codes  <= in_codes;
            prev_codes <= cur_codes;
         end
      end
   end

   // Tap i of channel j sees serial sample k-i.
   for (genvar j = 0; j < `FFE_WIDTH; j++) begin : g_ch
      for (genvar i = 0; i < `FFE_LENGTH; i++) begin : g_tap
         if (i <= j) begin : g_cur
            assign tap_x[j][i] = cur_codes[j-i];
         end else begin : g_hist
            assign tap_x[j][i] = prev_codes[`FFE_WIDTH+j-i];   // Older block.
         end
      end
   end

   // Stage one: all products.
   always_ff @(posedge clk) begin
      if (blk_valid) begin
         for (int j = 0; j < `FFE_WIDTH; j++) begin
            for (int i = 0; i < `FFE_LENGTH; i++) begin
               prod[j][i] <= product_t'(tap_x[j][i]) * product_t'(weights[i][j]);
            end
         end
      end
   end

   always_comb begin
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         tap_sum[j] = '0;
         for (int i = 0; i < `FFE_LENGTH; i++) tap_sum[j] = tap_sum[j] + acc_t'(prod[j][i]);
      end
   end

   // Stage two: per-channel sums.
   always_ff @(posedge clk) begin
      if (prod_valid) acc <= tap_sum;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prod_valid <= 1'b0;
         acc_valid  <= 1'b0;
      end else begin
         prod_valid <= blk_valid;
         acc_valid  <= prod_valid;
      end
   end

endmodule

// File: verilog/ffe_result_stage.sv
`timescale 1ns/100ps
`include "ffe_config.svh"

module ffe_result_stage (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  acc_valid,
   input  ffe_dsp_pkg::acc_t     acc         [`FFE_WIDTH-1:0],
   input  ffe_dsp_pkg::shift_t   shifts      [`FFE_WIDTH-1:0],
   output logic                  out_valid,
   output ffe_dsp_pkg::result_t  out_results [`FFE_WIDTH-1:0]
);
   import ffe_dsp_pkg::*;

   // Result range expressed in accumulator precision.
   localparam acc_t SAT_MAX = acc_t'(2 ** (`FFE_RESULT_BITS - 1) - 1);
   localparam acc_t SAT_MIN = acc_t'(-(2 ** (`FFE_RESULT_BITS - 1)));

   acc_t    shifted [`FFE_WIDTH-1:0];
   result_t clamped [`FFE_WIDTH-1:0];

   always_comb begin
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         shifted[j] = acc[j] >>> shifts[j];     // Floor, no rounding.
         if (shifted[j] > SAT_MAX)
            clamped[j] = result_t'(SAT_MAX);
         else if (shifted[j] < SAT_MIN)
            clamped[j] = result_t'(SAT_MIN);
         else
            clamped[j] = result_t'(shifted[j]);
      end
   end

   always_ff @(posedge clk) begin
      if (acc_valid) out_results <= clamped;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) out_valid <= 1'b0;
      else        out_valid <= acc_valid;
   end

endmodule

// File: verilog/ffe_top.sv
`timescale 1ns/100ps
`include "ffe_config.svh"

module ffe_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ffe_bus_pkg::axi_addr_t awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  ffe_bus_pkg::axi_data_t wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output ffe_bus_pkg::axi_resp_t bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  ffe_bus_pkg::axi_addr_t araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output ffe_bus_pkg::axi_data_t rdata,
   output ffe_bus_pkg::axi_resp_t rresp,
   output logic                   rvalid,
   input  logic                   rready,
   input  logic                   in_valid,
   input  ffe_dsp_pkg::code_t     in_codes    [`FFE_WIDTH-1:0],
   output logic                   out_valid,
   output ffe_dsp_pkg::result_t   out_results [`FFE_WIDTH-1:0]
);
   import ffe_dsp_pkg::*;

   weight_t weights [`FFE_LENGTH-1:0][`FFE_WIDTH-1:0];
   shift_t  shifts  [`FFE_WIDTH-1:0];
   logic    acc_valid;
   acc_t    acc     [`FFE_WIDTH-1:0];

   // Register decode.
   ffe_csr u_csr (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .weights (weights),
      .shifts  (shifts)
   );

   ffe_mac_array u_mac (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_codes  (in_codes),
      .weights   (weights),
      .acc_valid (acc_valid),
      .acc       (acc)
   );

   ffe_result_stage u_result (
      .clk         (clk),
      .rst_n       (rst_n),
      .acc_valid   (acc_valid),
      .acc         (acc),
      .shifts      (shifts),
      .out_valid   (out_valid),
      .out_results (out_results)
   );

endmodule

// File: bench/ffe_tb.sv
`timescale 1ns/100ps
`include "ffe_config.svh"

module ffe_tb;
   import ffe_dsp_pkg::*;
   import ffe_bus_pkg::*;

   localparam int TAPS = `FFE_LENGTH;
   localparam int CHANS = `FFE_WIDTH;
   localparam int WB = `FFE_WEIGHT_BITS;
   localparam int RB = `FFE_RESULT_BITS;
   localparam int CB = `FFE_CODE_BITS;
   localparam int MAX_CYCLES = 4000;    // Generous bound on the full run.
   localparam longint RES_MAX = 2 ** (RB - 1) - 1;
   localparam longint RES_MIN = -(2 ** (RB - 1));
   localparam code_t CODE_MAX = code_t'(2 ** (CB - 1) - 1);
   localparam code_t CODE_MIN = code_t'(-(2 ** (CB - 1)));

   typedef logic [CHANS*RB-1:0] block_t;

   logic      clk;
   logic      rst_n;
   axi_addr_t awaddr;
   logic      awvalid;
   logic      awready;
   axi_data_t wdata;
   logic [3:0] wstrb;
   logic      wvalid;
   logic      wready;
   axi_resp_t bresp;
   logic      bvalid;
   logic      bready;
   axi_addr_t araddr;
   logic      arvalid;
   logic      arready;
   axi_data_t rdata;
   axi_resp_t rresp;
   logic      rvalid;
   logic      rready;
   logic      in_valid;
   code_t     in_codes [CHANS-1:0];
   logic      out_valid;
   result_t   out_results [CHANS-1:0];

   // Reference model state.
   weight_t     w_model [TAPS-1:0][CHANS-1:0];
   shift_t      sh_model [CHANS-1:0];
   code_t       hist [TAPS-2:0];          // hist[0] is the newest past sample.
   code_t       blk [CHANS-1:0];          // Next block to drive.
   block_t      exp_q [$];
   int          cyc_q [$];
   int          cyc;
   logic [15:0] lfsr_state;

   ffe_top uut (
      .clk (clk), .rst_n (rst_n),
      .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
      .in_valid (in_valid), .in_codes (in_codes),
      .out_valid (out_valid), .out_results (out_results)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Taps 16, 14, 13 and 11.
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                            output axi_resp_t resp);
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'hf;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      #1;                               // Readies follow the valids combinationally.
      check("awready", 32'(awready), 32'd1);
      check("wready", 32'(wready), 32'd1);
      @(negedge clk);
      check("bvalid", 32'(bvalid), 32'd1);
      check("awready", 32'(awready), 32'd0);
      check("wready", 32'(wready), 32'd0);
      resp    = bresp;
      awvalid = 1'b0;                   // Accepted on the edge before bvalid.
      wvalid  = 1'b0;
   endtask

   task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                           output axi_resp_t resp);
      @(negedge clk);
      check("arready", 32'(arready), 32'd1);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      @(negedge clk);
      check("rvalid", 32'(rvalid), 32'd1);
      check("arready", 32'(arready), 32'd0);
      data    = rdata;
      resp    = rresp;
      arvalid = 1'b0;
   endtask

   task automatic set_weight(input int t, input int c, input axi_data_t data);
      axi_resp_t resp;
      axi_write(axi_addr_t'(`FFE_WEIGHT_BASE + 4 * (t * CHANS + c)), data, resp);
      check("bresp", 32'(resp), 32'(RESP_OKAY));
      w_model[t][c] = weight_t'(data[WB-1:0]);
   endtask

   task automatic set_shift(input int c, input axi_data_t data);
      axi_resp_t resp;
      axi_write(axi_addr_t'(`FFE_SHIFT_BASE + 4 * c), data, resp);
      check("bresp", 32'(resp), 32'(RESP_OKAY));
      sh_model[c] = shift_t'(data[`FFE_SHIFT_BITS-1:0]);
   endtask

   task automatic program_random();
      for (int t = 0; t < TAPS; t++) begin
         for (int c = 0; c < CHANS; c++) set_weight(t, c, random_bits(32));
      end
      for (int c = 0; c < CHANS; c++) set_shift(c, random_bits(32));
   endtask

   task automatic verify_registers();
      axi_data_t data;
      axi_resp_t resp;
      weight_t   w;
      for (int t = 0; t < TAPS; t++) begin
         for (int c = 0; c < CHANS; c++) begin
            axi_read(axi_addr_t'(`FFE_WEIGHT_BASE + 4 * (t * CHANS + c)), data, resp);
            w = w_model[t][c];
            check($sformatf("rdata weight[%0d][%0d]", t, c), data, {{(32-WB){w[WB-1]}}, w});
            check("rresp", 32'(resp), 32'(RESP_OKAY));
         end
      end
      for (int c = 0; c < CHANS; c++) begin
         axi_read(axi_addr_t'(`FFE_SHIFT_BASE + 4 * c), data, resp);
         check($sformatf("rdata shift[%0d]", c), data,
               {{(32-`FFE_SHIFT_BITS){1'b0}}, sh_model[c]});
         check("rresp", 32'(resp), 32'(RESP_OKAY));
      end
   endtask

   // FIR over the serial stream, floor shift, clamp.
   function automatic block_t expected_block();
      block_t b;
      longint sum;
      longint x;
      longint y;
      for (int j = 0; j < CHANS; j++) begin
         sum = 0;
         for (int i = 0; i < TAPS; i++) begin
            x = (i <= j) ? longint'(blk[j-i]) : longint'(hist[i-j-1]);
            sum = sum + x * longint'(w_model[i][j]);
         end
         y = sum >>> sh_model[j];
         if (y > RES_MAX) y = RES_MAX;
         else if (y < RES_MIN) y = RES_MIN;
         b[j*RB +: RB] = y[RB-1:0];
      end
      return b;
   endfunction

   task automatic send_block(input bit valid);
      @(negedge clk);
      in_valid = valid;
      for (int j = 0; j < CHANS; j++) in_codes[j] = blk[j];
      if (valid) begin
         exp_q.push_back(expected_block());
         cyc_q.push_back(cyc + 1);          // Edge that samples the block.
         for (int m = 0; m < TAPS - 1; m++) hist[m] = blk[CHANS-1-m];
      end
   endtask

   task automatic random_codes();
      for (int j = 0; j < CHANS; j++) blk[j] = code_t'(random_bits(CB));
   endtask

   task automatic drain();
      @(negedge clk);
      in_valid = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
   endtask

   task automatic run_stream(input int blocks, input bit gaps);
      int  sent;
      bit  v;
      sent = 0;
      while (sent < blocks) begin
         v = gaps ? (random_bits(1) != 0) : 1'b1;
         random_codes();
         send_block(v);
         if (v) sent++;
      end
      drain();
   endtask

   always @(posedge clk) begin
      cyc = cyc + 1;
      if (cyc > MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failed");
         $fatal(1);
      end
   end

   always @(negedge clk) begin : monitor
      block_t exp;
      int     c;
      if (rst_n && out_valid) begin
         if (exp_q.size() == 0) begin
            $display("Output block arrived with no input block pending");
            $display("Test failed");
            $fatal(1);
         end else begin
            exp = exp_q.pop_front();
            c = cyc_q.pop_front();
            check("out_valid latency", 32'(cyc - c), 32'd3);
            for (int j = 0; j < CHANS; j++)
               check($sformatf("out_results[%0d]", j), 32'(out_results[j]),
                     32'(result_t'(exp[j*RB +: RB])));
         end
      end
   end

   initial begin : main
      axi_data_t data;
      axi_resp_t resp;
      axi_data_t wt;
      cyc = 0;
      lfsr_state = 16'd33244;
      rst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = 4'h0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      in_valid = 1'b0;
      for (int j = 0; j < CHANS; j++) begin
         in_codes[j] = '0;
         blk[j] = '0;
         sh_model[j] = '0;
         for (int t = 0; t < TAPS; t++) w_model[t][j] = '0;
      end
      for (int m = 0; m < TAPS - 1; m++) hist[m] = '0;
      repeat (8) @(negedge clk);
      check("awready", 32'(awready), 32'd0);
      check("wready", 32'(wready), 32'd0);
      check("bvalid", 32'(bvalid), 32'd0);
      check("arready", 32'(arready), 32'd0);
      check("rvalid", 32'(rvalid), 32'd0);
      check("out_valid", 32'(out_valid), 32'd0);
      rst_n = 1'b1;
      @(negedge clk);
      check("arready", 32'(arready), 32'd1);   // Up in the first cycle after reset.

      // Register map round trip.
      program_random();
      verify_registers();

      // Unmapped address.
      axi_write(axi_addr_t'('h80), random_bits(32), resp);
      check("bresp", 32'(resp), 32'(RESP_SLVERR));
      axi_read(axi_addr_t'('h80), data, resp);
      check("rresp", 32'(resp), 32'(RESP_SLVERR));
      check("rdata", data, 32'h0);
      verify_registers();

      // Continuous stream from zero history.
      run_stream(200, 1'b0);

      // Full-scale weights drive both clamps.
      for (int t = 0; t < TAPS; t++) begin
         for (int c = 0; c < CHANS; c++) set_weight(t, c, 32'(2 ** (WB - 1) - 1));
      end
      for (int c = 0; c < CHANS; c++) set_shift(c, 32'h0);
      for (int b = 0; b < 6; b++) begin
         for (int j = 0; j < CHANS; j++) blk[j] = (b % 3 < 2) ? CODE_MAX : CODE_MIN;
         send_block(1'b1);
      end
      drain();

      // Same taps everywhere, distinct shift per channel.
      for (int t = 0; t < TAPS; t++) begin
         wt = random_bits(6);
         wt = {{26{wt[5]}}, wt[5:0]};
         for (int c = 0; c < CHANS; c++) set_weight(t, c, wt);
      end
      for (int c = 0; c < CHANS; c++) set_shift(c, 32'(2 * c) + random_bits(1));
      run_stream(40, 1'b0);

      // Idle gaps in the stream.
      program_random();
      run_stream(150, 1'b1);

      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: flist.f
+incdir+verilog
verilog/ffe_dsp_pkg.sv
verilog/ffe_bus_pkg.sv
verilog/ffe_csr.sv
verilog/ffe_mac_array.sv
verilog/ffe_result_stage.sv
verilog/ffe_top.sv
bench/ffe_tb.sv

// File: Makefile
# Verilator flow for the FFE block.

VERILATOR  ?= verilator
TOP        ?= ffe_tb
RTL_TOP    ?= ffe_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG   ?= Test failed
PASS_MSG   ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
